/* build.f */
+incdir+logic
logic/heapPkg.sv
logic/arrayAllocator.sv
logic/arrayStore.sv
logic/heapControl.sv
logic/heapTop.sv
sim/heapAssertions.sv
sim/heapTb.sv

/* Makefile */
SOURCES := build.f $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all run clean

all: obj_dir/VheapTb

obj_dir/VheapTb: $(SOURCES)
	verilator --binary --timing --assert -f build.f --top-module heapTb \
		-Mdir obj_dir -o VheapTb

# Pass only when the testbench prints its pass line
run: obj_dir/VheapTb
	@result="$$(./obj_dir/VheapTb +verilator+error+limit+1000)"; \
	echo "$$result"; \
	echo "$$result" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

/* sim/heapTb.sv */
//----------------------------------------
// Heap testbench with clock, reset, LFSR
// stimulus, reference model and checks
//----------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "heapCfg.svh"

module heapTb;
  import heapPkg::*;

  localparam int Arrays   = `HEAP_ARRAYS;
  localparam int Length   = `HEAP_LENGTH;
  localparam int DataMask = (1 << `HEAP_DATA_BITS) - 1;

  logic     clock;
  logic     reset;
  heapOp    action;
  arrayNum  array;
  elemIndex index;
  elemData  in;
  elemData  out;
  heapError error;

  elemData  expOutQ = '0;                           // Expectation set with the opcode
  heapError expErrQ = errNone;
  elemData  expOutP = '0;                           // Expectation delayed one cycle
  heapError expErrP = errNone;

  //----------------------------------------
  // Reference model state
  //----------------------------------------
  bit       mAlloc [Arrays];
  int       mSize  [Arrays];
  int       mElem  [Arrays][Length];
  int       mStack [$];                             // Freed numbers with newest last
  int       mFresh = 0;
  int       mOut   = 0;
  heapError mErr   = errNone;

  logic [15:0] lfsr     = 16'd11520;
  int          errors   = 0;
  int          timeouts = 0;

  heapTop dut (
    .clock(clock), .reset(reset), .action(action), .array(array),
    .index(index), .in(in), .out(out), .error(error)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;                      // 4 ns period
  end

  always @(posedge clock) begin
    expOutP <= expOutQ;                             // Lines up with DUT result
    expErrP <= expErrQ;
  end

  //----------------------------------------
  // Result checks on every cycle after reset
  //----------------------------------------
  outCheck: assert property (@(posedge clock) disable iff (reset) !reset |=> out == expOutP)
    else begin
      errors = errors + 1;
      $display("mismatch at %0t: out %0h, model %0h", $time, $sampled(out), $sampled(expOutP));
    end

  errCheck: assert property (@(posedge clock) disable iff (reset) !reset |=> error == expErrP)
    else begin
      errors = errors + 1;
      $display("mismatch at %0t: error %0d, model %0d", $time, $sampled(error),
               $sampled(expErrP));
    end

  // Galois LFSR stepped once per bit
  function automatic int randBits(int n);
    int   value;
    logic bitOut;
    value = 0;
    for (int b = 0; b < n; b++) begin
      bitOut = lfsr[0];
      lfsr   = lfsr >> 1;
      if (bitOut) lfsr = lfsr ^ 16'hB400;
      value  = (value << 1) | int'(bitOut);
    end
    return value;
  endfunction

  // Model step, then drive the opcode
  task automatic issue(heapOp op, int arr, int idx, int data);
    heapError err;
    int       n;
    err = errNone;
    n   = 0;
    if (op == opNone) err = mErr;                   // Idle keeps last error
    else if (op != opAlloc && !mAlloc[arr]) err = errNotAllocated;
    else begin
      case (op)
        opWrite: begin
          mElem[arr][idx] = data;
          if (idx >= mSize[arr]) mSize[arr] = idx + 1;
          mOut = data;
        end
        opRead: if (idx >= mSize[arr]) err = errOutOfBounds;
                else mOut = mElem[arr][idx];
        opSize: mOut = mSize[arr];
        opPush: if (mSize[arr] == Length) err = errFull;
                else begin
                  mElem[arr][mSize[arr]] = data;
                  mSize[arr]++;
                end
        opPop: if (mSize[arr] == 0) err = errEmpty;
               else begin
                 mSize[arr]--;
                 mOut = mElem[arr][mSize[arr]];
               end
        opResize: if (data > Length) err = errTooLarge;
                  else mSize[arr] = data;
        opAlloc: if (mStack.size() == 0 && mFresh == Arrays) err = errOutOfMemory;
                 else begin
                   if (mStack.size() != 0) n = mStack.pop_back(); // Newest free first
                   else begin
                     n = mFresh;
                     mFresh++;
                   end
                   mAlloc[n] = 1'b1;
                   mSize[n]  = 0;
                   mOut      = n;
                 end
        opFree: begin
          mAlloc[arr] = 1'b0;
          mStack.push_back(arr);
        end
        opAdd, opSub: if (idx >= mSize[arr]) err = errOutOfBounds;
                      else begin
                        n = (op == opAdd) ? mElem[arr][idx] + data : mElem[arr][idx] - data;
                        mElem[arr][idx] = n & DataMask; // Wrap at data width
                        mOut = mElem[arr][idx];
                      end
        default: ;
      endcase
    end
    mErr = err;
    @(posedge clock);
    action  <= op;
    array   <= arrayNum'(arr);
    index   <= elemIndex'(idx);
    in      <= elemData'(data);
    expOutQ <= elemData'(mOut);
    expErrQ <= mErr;
  endtask

  task automatic releaseReset();
    int cycles;
    cycles = 0;
    reset <= 1'b0;
    while (!(error == errNone && out == '0) && cycles < 16) begin
      @(posedge clock);
      cycles++;
    end
    if (!(error == errNone && out == '0)) begin
      timeouts++;
      $display("timeout: DUT did not show a clean state after reset");
    end
  endtask

  //----------------------------------------
  // Directed then random stimulus
  //----------------------------------------
  initial begin
    int code;
    int arr;
    int idx;
    int data;
    reset  = 1'b1;
    action = opNone;
    array  = '0;
    index  = '0;
    in     = '0;
    repeat (8) @(posedge clock);                    // Reset for 8 cycles
    releaseReset();
    for (int k = 0; k <= Arrays; k++) issue(opAlloc, 0, 0, 0); // Last runs out
    for (int a = 0; a < Arrays; a++) begin
      for (int i = 0; i < Length; i++) issue(opWrite, a, i, randBits(12)); // Size grows
      for (int i = 0; i < Length; i++) issue(opRead, a, i, 0);
      issue(opSize, a, 0, 0);
    end
    issue(opFree, 2, 0, 0);                         // Reuse of one free
    issue(opAlloc, 0, 0, 0);
    issue(opFree, 1, 0, 0);                         // Two frees come back reversed
    issue(opFree, 3, 0, 0);
    issue(opAlloc, 0, 0, 0);
    issue(opAlloc, 0, 0, 0);
    for (int a = 0; a < Arrays; a++) issue(opFree, a, 0, 0);
    issue(opFree, 0, 0, 0);                         // Second free is rejected
    issue(opRead, 1, 0, 0);
    issue(opWrite, 2, 1, 77);
    issue(opAlloc, 0, 0, 0);
    issue(opRead, 3, 0, 0);                         // Empty array gives out of bounds
    issue(opPop, 3, 0, 0);
    for (int k = 0; k <= Length; k++) issue(opPush, 3, 0, randBits(12));
    for (int k = 0; k <= Length; k++) issue(opPop, 3, 0, 0);
    issue(opResize, 3, 0, 3);
    issue(opSize, 3, 0, 0);
    issue(opResize, 3, 0, Length + 1);              // Too large so size stays
    issue(opSize, 3, 0, 0);
    issue(opAdd, 3, 1, randBits(12));
    issue(opRead, 3, 1, 0);
    issue(opSub, 3, 2, DataMask);                   // Wraps past zero
    issue(opRead, 3, 2, 0);
    for (int k = 0; k < 400; k++) begin
      code = randBits(4);
      arr  = randBits(2);
      idx  = randBits(2);
      data = (code == int'(opResize)) ? randBits(3) : randBits(12);
      issue((code > int'(opSub)) ? opNone : heapOp'(code[7:0]), arr, idx, data);
    end
    for (int k = 0; k < 3; k++) issue(opNone, 0, 0, 0); // Let last checks run
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/heapAssertions.sv */
//----------------------------------------
// Bound checks on heapTop
// Reset state and idle hold of results
//----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module heapAssertions (
  input logic              clock,
  input logic              reset,
  input heapPkg::heapOp    action,
  input heapPkg::elemData  out,
  input heapPkg::heapError error
);
  import heapPkg::*;

  // Results are cleared by reset
  resetClear: assert property (@(posedge clock) reset |=> (error == errNone && out == '0))
    else $error("error or out not cleared by reset");

  // Idle opcode leaves both results alone
  idleHold: assert property (@(posedge clock) disable iff (reset)
    (action == opNone) |=> ($stable(out) && $stable(error)))
    else $error("out or error changed during an idle cycle");

endmodule

bind heapTop heapAssertions checks (
  .clock(clock), .reset(reset), .action(action), .out(out), .error(error)
);

`default_nettype wire

/* logic/heapTop.sv */
//----------------------------------------
// Heap top: controller, allocator, store
//----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module heapTop (
  input  logic              clock,
  input  logic              reset,
  input  heapPkg::heapOp    action,                 // One opcode per cycle
  input  heapPkg::arrayNum  array,
  input  heapPkg::elemIndex index,
  input  heapPkg::elemData  in,
  output heapPkg::elemData  out,                    // Result, one cycle later
  output heapPkg::heapError error
);
  import heapPkg::*;

  logic     allocated, canAllocate, allocate, releaseArray; // Allocator handshake
  arrayNum  nextArray, targetArray;
  elemIndex readIndex, writeIndex;
  logic     writeEnable, sizeEnable;                // Store updates
  elemData  writeData, readData;
  arraySize newSize, size;

  heapControl control (
    .clock(clock), .reset(reset),
    .action(action), .array(array), .index(index), .in(in),
    .allocated(allocated), .canAllocate(canAllocate), .nextArray(nextArray),
    .size(size), .readData(readData),
    .allocate(allocate), .releaseArray(releaseArray), .targetArray(targetArray),
    .readIndex(readIndex), .writeIndex(writeIndex),
    .writeEnable(writeEnable), .sizeEnable(sizeEnable),
    .writeData(writeData), .newSize(newSize),
    .out(out), .error(error)
  );

  // Flags and frees follow the requested array
  arrayAllocator allocator (
    .clock(clock), .reset(reset),
    .allocate(allocate), .releaseArray(releaseArray), .array(array),
    .allocated(allocated), .canAllocate(canAllocate), .nextArray(nextArray)
  );

  // Store select switches to nextArray on allocate
  arrayStore store (
    .clock(clock), .reset(reset),
    .array(targetArray), .readIndex(readIndex),
    .writeEnable(writeEnable), .writeIndex(writeIndex), .writeData(writeData),
    .sizeEnable(sizeEnable), .newSize(newSize),
    .readData(readData), .size(size)
  );

endmodule

`default_nettype wire

/* logic/heapControl.sv */
//----------------------------------------
// Heap controller: opcode decode, checks,
// element arithmetic, registered results
//----------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "heapCfg.svh"

module heapControl (
  input  logic               clock,
  input  logic               reset,
  input  heapPkg::heapOp     action,                // Opcode, opNone when idle
  input  heapPkg::arrayNum   array,
  input  heapPkg::elemIndex  index,
  input  heapPkg::elemData   in,
  input  logic               allocated,             // From allocator
  input  logic               canAllocate,
  input  heapPkg::arrayNum   nextArray,
  input  heapPkg::arraySize  size,                  // From store
  input  heapPkg::elemData   readData,
  output logic               allocate,              // To allocator
  output logic               releaseArray,
  output heapPkg::arrayNum   targetArray,           // To store
  output heapPkg::elemIndex  readIndex,
  output heapPkg::elemIndex  writeIndex,
  output logic               writeEnable,
  output logic               sizeEnable,
  output heapPkg::elemData   writeData,
  output heapPkg::arraySize  newSize,
  output heapPkg::elemData   out,
  output heapPkg::heapError  error
);
  import heapPkg::*;

  heapError errNext;                                // Outcome of this opcode
  logic     pass;                                   // No check failed
  logic     accept;                                 // Known non-idle opcode
  logic     outLoad;                                // Opcode returns a value
  elemData  outNext;
  elemData  sum;
  elemData  diff;
  arraySize indexPlus;                              // Size after write at index
  arraySize sizeUp;
  arraySize sizeDown;
  logic     inBounds;
  logic     notFull;
  logic     notEmpty;
  logic     inFits;

  //----------------------------------------
  // Datapath helpers
  //----------------------------------------
  assign targetArray = (action == opAlloc) ? nextArray : array; // Clear size of new array
  assign sum         = readData + in;               // Wraps at data width
  assign diff        = readData - in;
  assign indexPlus   = {1'b0, index} + 1'b1;
  assign sizeUp      = size + 1'b1;
  assign sizeDown    = size - 1'b1;
  assign inBounds    = ({1'b0, index} < size);
  assign notFull     = (size != arraySize'(`HEAP_LENGTH));
  assign notEmpty    = (size != '0);
  assign inFits      = (in <= elemData'(`HEAP_LENGTH));
  assign pass        = (errNext == errNone);

  //----------------------------------------
  // Legality checks
  //----------------------------------------
  always_comb begin
    errNext = errNone;
    if (action != opNone && action != opAlloc && !allocated) begin
      errNext = errNotAllocated;                    // Covers freed arrays too
    end else begin
      case (action)
        opRead, opAdd, opSub: if (!inBounds)    errNext = errOutOfBounds;
        opPush:               if (!notFull)     errNext = errFull;
        opPop:                if (!notEmpty)    errNext = errEmpty;
        opResize:             if (!inFits)      errNext = errTooLarge;
        opAlloc:              if (!canAllocate) errNext = errOutOfMemory;
        default: ;
      endcase
    end
  end

  //----------------------------------------
  // Updates and result, gated by pass
  //----------------------------------------
  always_comb begin
    accept       = 1'b1;
    outLoad      = 1'b0;
    outNext      = readData;                        // Read and pop
    allocate     = 1'b0;
    releaseArray = 1'b0;
    readIndex    = index;
    writeEnable  = 1'b0;
    writeIndex   = index;
    writeData    = in;
    sizeEnable   = 1'b0;
    newSize      = size;
    case (action)
      opWrite: begin
        writeEnable = pass;
        sizeEnable  = pass && !inBounds;            // Grow to index plus one
        newSize     = indexPlus;
        outLoad     = 1'b1;
        outNext     = in;
      end
      opRead: outLoad = 1'b1;
      opSize: begin
        outLoad = 1'b1;
        outNext = elemData'(size);
      end
      opPush: begin
        writeEnable = pass;
        writeIndex  = size[`HEAP_INDEX_BITS-1:0];   // First free slot
        sizeEnable  = pass;
        newSize     = sizeUp;
      end
      opPop: begin
        readIndex  = sizeDown[`HEAP_INDEX_BITS-1:0]; // Last element
        sizeEnable = pass;
        newSize    = sizeDown;
        outLoad    = 1'b1;
      end
      opResize: begin
        sizeEnable = pass;
        newSize    = arraySize'(in);                // Fits once inFits holds
      end
      opAlloc: begin
        allocate   = pass;
        sizeEnable = pass;                          // New array starts empty
        newSize    = '0;
        outLoad    = 1'b1;
        outNext    = elemData'(nextArray);
      end
      opFree: releaseArray = pass;
      opAdd: begin
        writeEnable = pass;
        writeData   = sum;
        outLoad     = 1'b1;
        outNext     = sum;
      end
      opSub: begin
        writeEnable = pass;
        writeData   = diff;
        outLoad     = 1'b1;
        outNext     = diff;
      end
      default: accept = 1'b0;                       // Idle or unknown code
    endcase
  end

  //----------------------------------------
  // Registered out and error
  //----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= errNone;
    end else if (accept) begin
      error <= errNext;
      if (outLoad && pass) out <= outNext;          // Failure keeps old out
    end
  end

endmodule

`default_nettype wire

/* logic/arrayStore.sv */
//----------------------------------------
// Element registers and array sizes
// Combinational read, clocked update
//----------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "heapCfg.svh"

module arrayStore (
  input  logic              clock,
  input  logic              reset,
  input  heapPkg::arrayNum  array,                  // Selected array
  input  heapPkg::elemIndex readIndex,              // Element on readData
  input  logic              writeEnable,
  input  heapPkg::elemIndex writeIndex,
  input  heapPkg::elemData  writeData,
  input  logic              sizeEnable,             // Load newSize
  input  heapPkg::arraySize newSize,
  output heapPkg::elemData  readData,
  output heapPkg::arraySize size                    // Size of selected array
);
  import heapPkg::*;

  elemData  elements [`HEAP_ARRAYS][`HEAP_LENGTH];  // Fixed block per array
  arraySize sizes    [`HEAP_ARRAYS];                // Live element count

  //----------------------------------------
  // Read side
  //----------------------------------------
  assign readData = elements[array][readIndex];
  assign size     = sizes[array];

  //----------------------------------------
  // Element writes
  //----------------------------------------
  always_ff @(posedge clock) begin
    if (writeEnable) begin
      elements[array][writeIndex] <= writeData;     // Past size is fine, size decides
    end
  end

  //----------------------------------------
  // Size updates
  //----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < `HEAP_ARRAYS; a++) begin
        sizes[a] <= '0;                             // Every array empty
      end
    end else if (sizeEnable) begin
      sizes[array] <= newSize;
    end
  end

endmodule

`default_nettype wire

/* logic/arrayAllocator.sv */
//----------------------------------------
// Array allocator: freed number LIFO,
// allocated flags, fresh number counter
//----------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "heapCfg.svh"

module arrayAllocator (
  input  logic             clock,
  input  logic             reset,
  input  logic             allocate,                // Take nextArray
  input  logic             releaseArray,            // Give back array
  input  heapPkg::arrayNum array,                   // Array of the request
  output logic             allocated,               // Flag of array
  output logic             canAllocate,             // Some array is free
  output heapPkg::arrayNum nextArray                // Number an allocate returns
);
  import heapPkg::*;

  arrayNum                     freeStack [`HEAP_ARRAYS]; // Freed numbers, newest on top
  logic [`HEAP_ARRAY_BITS:0]   stackTop;            // Entries on the stack
  logic [`HEAP_ARRAY_BITS:0]   topBelow;            // Slot of the newest entry
  logic [`HEAP_ARRAY_BITS:0]   freshCount;          // Numbers never handed out start here
  logic [`HEAP_ARRAYS-1:0]     allocFlags;          // One per array
  logic                        stackEmpty;

  //----------------------------------------
  // Answers to the controller
  //----------------------------------------
  assign topBelow   = stackTop - 1'b1;
  assign stackEmpty = (stackTop == '0);
  assign allocated  = allocFlags[array];

  // Counter top bit set means every number went out once
  assign canAllocate = !stackEmpty || !freshCount[`HEAP_ARRAY_BITS];

  // Reuse the most recent free, else a fresh number
  assign nextArray = stackEmpty ? freshCount[`HEAP_ARRAY_BITS-1:0]
                                : freeStack[topBelow[`HEAP_ARRAY_BITS-1:0]];

  //----------------------------------------
  // Control state
  //----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      stackTop   <= '0;                             // Nothing freed yet
      freshCount <= '0;
      allocFlags <= '0;                             // No array in use
    end else if (allocate) begin
      if (stackEmpty) freshCount <= freshCount + 1'b1;
      else            stackTop   <= topBelow;       // Pop the reused number
      allocFlags[nextArray] <= 1'b1;
    end else if (releaseArray) begin
      stackTop          <= stackTop + 1'b1;         // Push the freed number
      allocFlags[array] <= 1'b0;
    end
  end

  // Stack contents, only slots below stackTop are meaningful
  always_ff @(posedge clock) begin
    if (releaseArray && !allocate) begin
      freeStack[stackTop[`HEAP_ARRAY_BITS-1:0]] <= array;
    end
  end

endmodule

`default_nettype wire

/* logic/heapPkg.sv */
//----------------------------------------
// Heap opcodes and error kinds
// Array number, index, data, size types
//----------------------------------------
`default_nettype none

`include "heapCfg.svh"

package heapPkg;

  //----------------------------------------
  // Operations, opNone is an idle cycle
  //----------------------------------------
  typedef enum logic [7:0] {
    opNone   = 8'd0,                                // No request
    opWrite  = 8'd1,                                // Store element, grow size
    opRead   = 8'd2,                                // Fetch element
    opSize   = 8'd3,                                // Current size
    opPush   = 8'd4,                                // Append at size
    opPop    = 8'd5,                                // Remove last element
    opResize = 8'd6,                                // Set size from in
    opAlloc  = 8'd7,                                // Hand out an array
    opFree   = 8'd8,                                // Give an array back
    opAdd    = 8'd9,                                // Element plus in
    opSub    = 8'd10                                // Element minus in
  } heapOp;

  typedef enum logic [2:0] {
    errNone,                                        // Success
    errNotAllocated,                                // Array not in use
    errOutOfBounds,                                 // Index at or past size
    errFull,                                        // Push onto full array
    errEmpty,                                       // Pop from empty array
    errTooLarge,                                    // Resize past length
    errOutOfMemory                                  // No array left
  } heapError;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNum;    // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIndex;   // Element index
  typedef logic [`HEAP_DATA_BITS-1:0]  elemData;    // Element value
  typedef logic [`HEAP_INDEX_BITS:0]   arraySize;   // Holds 0 up to full length

endpackage

`default_nettype wire

/* logic/heapCfg.svh */
//----------------------------------------
// Widths and counts of the array heap
//----------------------------------------
`ifndef HEAP_CFG_SVH
`define HEAP_CFG_SVH

//----------------------------------------
// Base widths
//----------------------------------------
`define HEAP_ARRAY_BITS 2                           // Bits in an array number
`define HEAP_INDEX_BITS 2                           // Bits in an element index
`define HEAP_DATA_BITS  12                          // Bits in one element

// Counts follow from the widths
`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)         // Arrays in the bank
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)         // Elements per array

`endif
